// ==== Makefile ====
# Verilator build and run for the deaggregator testbench
# every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_deagg
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0
PASS_MSG  ?= *** TEST PASSED ***

# sources are read from the file list so the binary tracks every edit
SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail, a missing pass line fails the target
run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q -F '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== deagg_pkg.sv ====
package deagg_pkg;

  // width of one narrow lane as it leaves the output FIFO
  localparam int DATA_WIDTH = 16;

  // number of narrow lanes packed into one fetch word
  localparam int FETCH_WIDTH = 4;

  // enough bits to index any lane of a fetch word
  localparam int LANE_SEL_WIDTH = $clog2(FETCH_WIDTH);

  // each lane FIFO holds this many beats
  localparam int LANE_DEPTH = 3;

  // depth of the FIFO that faces the outside reader
  localparam int OUT_DEPTH = 4;

  // the credit counter must be able to reach LANE_DEPTH itself
  localparam int CREDIT_WIDTH = $clog2(LANE_DEPTH + 1);

  // one fetch word seen two ways
  // the writer and the double buffer move it as one flat vector,
  // while the deaggregator picks it apart lane by lane
  typedef union packed {
    logic [FETCH_WIDTH*DATA_WIDTH-1:0]      flat;
    logic [FETCH_WIDTH-1:0][DATA_WIDTH-1:0] lanes;
  } fetch_word_u;

  // one narrow beat on its way to the reader
  // last is set only on the top lane of its fetch word
  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic                  last;
  } beat_t;

endpackage

// ==== deagg_top.sv ====
`timescale 1ns/1ps

module deagg_top import deagg_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  fetch_word_u in_word,
  input  logic        in_enq,
  output logic        in_full_n,
  output beat_t       out_beat,
  input  logic        out_deq,
  output logic        out_empty_n
);

  // double buffer to deaggregator
  fetch_word_u db_word;
  logic        db_empty_n;
  logic        db_deq;

  // deaggregator to output FIFO
  beat_t recv_beat;
  logic  recv_full_n;
  logic  recv_enq;

  // the writer fills this two-entry store with whole fetch words
  double_buffer u_double_buffer (
    .clk            (clk),
    .rst_n          (rst_n),
    .in_word        (in_word),
    .in_enq         (in_enq),
    .in_full_n      (in_full_n),
    .sender_word    (db_word),
    .sender_deq     (db_deq),
    .sender_empty_n (db_empty_n)
  );

  // splits each word into lanes and hands them out lowest lane first
  deaggregator u_deaggregator (
    .clk            (clk),
    .rst_n          (rst_n),
    .sender_word    (db_word),
    .sender_empty_n (db_empty_n),
    .sender_deq     (db_deq),
    .recv_beat      (recv_beat),
    .recv_full_n    (recv_full_n),
    .recv_enq       (recv_enq)
  );

  // output queue, the reader pulls narrow beats from here
  // when it fills, recv_full_n stalls the lanes and back-pressure spreads upstream
  lane_fifo #(
    .DEPTH (OUT_DEPTH)
  ) u_out_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .din     (recv_beat),
    .enq     (recv_enq),
    .full_n  (recv_full_n),
    .dout    (out_beat),
    .deq     (out_deq),
    .empty_n (out_empty_n)
  );

endmodule

// ==== deaggregator.sv ====
`timescale 1ns/1ps

module deaggregator import deagg_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  fetch_word_u sender_word,
  input  logic        sender_empty_n,
  output logic        sender_deq,
  output beat_t       recv_beat,
  input  logic        recv_full_n,
  output logic        recv_enq
);

  // beats going into and coming out of the lane FIFOs
  beat_t lane_din  [FETCH_WIDTH];
  beat_t lane_dout [FETCH_WIDTH];

  logic [FETCH_WIDTH-1:0] lane_empty_n;
  logic [FETCH_WIDTH-1:0] lane_deq;

  // lane that is next in line for the output FIFO
  logic [LANE_SEL_WIDTH-1:0] lane_sel_q;

  // words held in the top lane plus the read still in flight
  logic [CREDIT_WIDTH-1:0] credit_q;

  // the double buffer answers one cycle after a dequeue,
  // so the lane enqueue is the dequeue delayed by one edge
  logic lane_enq_q;

  logic drain_last;

  genvar i;
  generate
    for (i = 0; i < FETCH_WIDTH; i++) begin : g_lane
      // lane i takes its slice of the word, last is marked on the top lane only
      assign lane_din[i] = '{data: sender_word.lanes[i], last: (i == FETCH_WIDTH - 1)};

      // only the selected lane may drain, and only when the output has room
      assign lane_deq[i] = recv_enq && (lane_sel_q == LANE_SEL_WIDTH'(i));

      // the credit counter guarantees room, so the lane full flag is not needed
      lane_fifo #(
        .DEPTH (LANE_DEPTH)
      ) u_lane_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .din     (lane_din[i]),
        .enq     (lane_enq_q),
        .full_n  (),
        .dout    (lane_dout[i]),
        .deq     (lane_deq[i]),
        .empty_n (lane_empty_n[i])
      );
    end
  endgenerate

  // output side, one beat per cycle in lane order
  assign recv_beat = lane_dout[lane_sel_q];
  assign recv_enq  = recv_full_n && lane_empty_n[lane_sel_q];

  // lanes drain in order, so once the top lane drains the whole word is gone
  assign drain_last = lane_deq[FETCH_WIDTH-1];

  // lane full flags lag a read in flight by a cycle and cannot gate the read;
  // tracking the top lane alone is enough, since it is always the last to drain
  assign sender_deq = sender_empty_n && (credit_q < CREDIT_WIDTH'(LANE_DEPTH));

  always_ff @(posedge clk) begin
    if (rst_n) begin
      lane_enq_q <= 1'b0;
      lane_sel_q <= '0;
      credit_q   <= '0;
    end else begin
      lane_enq_q <= sender_deq;

      // step to the next lane after each beat, back to 0 past the top lane
      if (recv_enq) begin
        if (lane_sel_q == LANE_SEL_WIDTH'(FETCH_WIDTH - 1)) begin
          lane_sel_q <= '0;
        end else begin
          lane_sel_q <= lane_sel_q + LANE_SEL_WIDTH'(1);
        end
      end

      // a read and a top lane drain in the same cycle cancel out
      case ({sender_deq, drain_last})
        2'b10:   credit_q <= credit_q + CREDIT_WIDTH'(1);
        2'b01:   credit_q <= credit_q - CREDIT_WIDTH'(1);
        default: credit_q <= credit_q;
      endcase
    end
  end

endmodule

// ==== double_buffer.sv ====
`timescale 1ns/1ps

module double_buffer import deagg_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  fetch_word_u in_word,
  input  logic        in_enq,
  output logic        in_full_n,
  output fetch_word_u sender_word,
  input  logic        sender_deq,
  output logic        sender_empty_n
);

  // two word slots used in ping-pong order
  fetch_word_u word_q [2];

  // registered read port, the deaggregator samples it one cycle after a dequeue
  fetch_word_u rd_word_q;

  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] count_q;
  logic       wr_en;
  logic       rd_en;

  // full when both slots hold a word, empty when neither does
  assign in_full_n      = (count_q != 2'd2);
  assign sender_empty_n = (count_q != 2'd0);

  // ignore requests that break the handshake rather than corrupt the count
  assign wr_en = in_enq && in_full_n;
  assign rd_en = sender_deq && sender_empty_n;

  assign sender_word = rd_word_q;

  // slot storage and the read register carry payload only
  always_ff @(posedge clk) begin
    if (wr_en) begin
      word_q[wr_ptr_q].flat <= in_word.flat;
    end
    // a dequeue copies the head into the read register,
    // and the word then stays there until the next dequeue
    if (rd_en) begin
      rd_word_q.flat <= word_q[rd_ptr_q].flat;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      // with two slots each pointer simply toggles
      if (wr_en) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (rd_en) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      // the freed slot shows up in the count on the next edge
      case ({wr_en, rd_en})
        2'b10:   count_q <= count_q + 2'd1;
        2'b01:   count_q <= count_q - 2'd1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// ==== lane_fifo.sv ====
`timescale 1ns/1ps

module lane_fifo import deagg_pkg::*; #(
  parameter int DEPTH = 4
) (
  input  logic  clk,
  input  logic  rst_n,
  input  beat_t din,
  input  logic  enq,
  output logic  full_n,
  output beat_t dout,
  input  logic  deq,
  output logic  empty_n
);

  // pointers index the storage, the count must also reach DEPTH
  typedef logic [$clog2(DEPTH)-1:0]   ptr_t;
  typedef logic [$clog2(DEPTH+1)-1:0] count_t;

  beat_t  mem [DEPTH];
  ptr_t   wr_ptr_q;
  ptr_t   rd_ptr_q;
  count_t count_q;
  logic   do_enq;
  logic   do_deq;

  // status comes straight from the occupancy count
  assign full_n  = (count_q != count_t'(DEPTH));
  assign empty_n = (count_q != count_t'(0));

  // a dequeue on a full FIFO frees the head in the same edge,
  // so an enqueue in that cycle is accepted as well
  assign do_deq = deq && empty_n;
  assign do_enq = enq && (full_n || do_deq);

  // head entry is read combinationally
  assign dout = mem[rd_ptr_q];

  always_ff @(posedge clk) begin
    if (do_enq) begin
      mem[wr_ptr_q] <= din;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // the depth need not be a power of two, so wrap explicitly
      if (do_enq) begin
        if (wr_ptr_q == ptr_t'(DEPTH - 1)) begin
          wr_ptr_q <= '0;
        end else begin
          wr_ptr_q <= wr_ptr_q + ptr_t'(1);
        end
      end
      if (do_deq) begin
        if (rd_ptr_q == ptr_t'(DEPTH - 1)) begin
          rd_ptr_q <= '0;
        end else begin
          rd_ptr_q <= rd_ptr_q + ptr_t'(1);
        end
      end
      // count only moves when exactly one side is active
      case ({do_enq, do_deq})
        2'b10:   count_q <= count_q + count_t'(1);
        2'b01:   count_q <= count_q - count_t'(1);
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// ==== tb_deagg.sv ====
`timescale 1ns/1ps

module tb_deagg import deagg_pkg::*; ();

  // words written in each phase of the run
  localparam int STEADY_WORDS = 40;
  localparam int RANDOM_WORDS = 300;
  localparam int BP_WORDS     = 20;
  localparam int TOTAL_WORDS  = STEADY_WORDS + RANDOM_WORDS + BP_WORDS;

  // each beat may take many cycles under random stalls on both sides
  localparam int CYCLE_LIMIT = 40 * TOTAL_WORDS * FETCH_WIDTH;

  // in_full_n has to drop this soon once the reader stops
  localparam int BP_WINDOW = 30;

  // every beat still held inside the DUT leaves well within this many cycles
  localparam int DRAIN_LIMIT = 200;

  // the output must stay quiet this long after the model runs dry
  localparam int QUIET_CYCLES = 20;

  logic        clk;
  logic        rst_n;
  fetch_word_u in_word;
  logic        in_enq;
  logic        in_full_n;
  beat_t       out_beat;
  logic        out_deq;
  logic        out_empty_n;

  // expected beats in the order the reader should see them
  beat_t exp_q [$];

  logic [31:0] lfsr_state = 32'hdbad;

  int cycle_count   = 0;
  int words_sent    = 0;
  int beat_errors   = 0;
  int status_errors = 0;
  int other_errors  = 0;

  deagg_top UUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_word     (in_word),
    .in_enq      (in_enq),
    .in_full_n   (in_full_n),
    .out_beat    (out_beat),
    .out_deq     (out_deq),
    .out_empty_n (out_empty_n)
  );

  initial begin
    clk = 1'b0;
  end

  always #5 clk = ~clk;

  // the watchdog stops a run that stalls or never drains
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("errors: beat %0d, status %0d, other %0d",
               beat_errors, status_errors, other_errors + 1);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // galois form of x^32 + x^22 + x^2 + x + 1 shifting right
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h8020_0003;
    end
    return n;
  endfunction

  // one step of the generator for every bit handed out
  function automatic logic next_bit();
    lfsr_state = lfsr_step(lfsr_state);
    return lfsr_state[0];
  endfunction

  function automatic logic [63:0] random_word();
    logic [63:0] v;
    v = '0;
    for (int b = 0; b < 64; b++) begin
      v = {v[62:0], next_bit()};
    end
    return v;
  endfunction

  task automatic check_beat(input string name, input beat_t got, input beat_t exp);
    if (got !== exp) begin
      beat_errors++;
      $display("Mismatch at %0t: %s got data=%h last=%b, expected data=%h last=%b",
               $time, name, got.data, got.last, exp.data, exp.last);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      status_errors++;
      $display("Mismatch at %0t: %s got %b, expected %b", $time, name, got, exp);
    end
  endtask

  // a fetch word leaves as its lanes with the lowest first and last on the top lane
  task automatic push_word(input fetch_word_u w);
    beat_t b;
    for (int l = 0; l < FETCH_WIDTH; l++) begin
      b.data = w.lanes[l];
      b.last = (l == FETCH_WIDTH - 1);
      exp_q.push_back(b);
    end
  endtask

  task automatic pop_and_check();
    beat_t exp;
    if (exp_q.size() == 0) begin
      other_errors++;
      $display("at %0t the DUT offered a beat that was never written", $time);
    end else begin
      exp = exp_q.pop_front();
      check_beat("out_beat", out_beat, exp);
    end
  endtask

  // one clock cycle of stimulus
  // status is registered, so it is stable 1 ns after the edge and decides
  // what the handshakes do at the next edge
  task automatic run_cycle(input logic try_enq, input logic try_deq);
    fetch_word_u w;
    @(posedge clk);
    #1;
    in_enq  = 1'b0;
    out_deq = 1'b0;
    if (try_enq && in_full_n) begin
      w.flat  = random_word();
      in_word = w;
      in_enq  = 1'b1;
      push_word(w);
      words_sent++;
    end
    if (try_deq && out_empty_n) begin
      out_deq = 1'b1;
      pop_and_check();
    end
  endtask

  initial begin
    int   target;
    int   waited;
    logic saw_full;
    logic try_enq;
    logic try_deq;

    rst_n       = 1'b1;
    in_word     = '0;
    in_enq      = 1'b0;
    out_deq     = 1'b0;

    // reset is active high and lasts two cycles
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b0;

    @(posedge clk);
    #1;
    check_bit("in_full_n", in_full_n, 1'b1);
    check_bit("out_empty_n", out_empty_n, 1'b0);

    // steady writes and reads check lane order and the last flag against the model
    target = words_sent + STEADY_WORDS;
    while (words_sent < target) begin
      run_cycle(1'b1, 1'b1);
    end

    // random traffic on both sides with a somewhat keener reader
    target = words_sent + RANDOM_WORDS;
    while (words_sent < target) begin
      try_enq = next_bit();
      try_deq = next_bit() | next_bit();
      run_cycle(try_enq, try_deq);
    end

    // with the reader stopped the stall has to reach the write side
    target   = words_sent + BP_WORDS;
    waited   = 0;
    saw_full = 1'b0;
    while (!saw_full && waited < BP_WINDOW) begin
      run_cycle(1'b1, 1'b0);
      waited++;
      if (!in_full_n) begin
        saw_full = 1'b1;
      end
    end
    if (!saw_full) begin
      other_errors++;
      $display("in_full_n stayed high for %0d cycles with the reader stopped", BP_WINDOW);
    end

    // once reads resume everything held back must come out in order
    while (words_sent < target) begin
      run_cycle(1'b1, 1'b1);
    end

    // the writer is idle now and a stuck beat stays behind in the model
    waited = 0;
    while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
      run_cycle(1'b0, 1'b1);
      waited++;
    end

    // any beat offered now is a duplicate or an invented one
    repeat (QUIET_CYCLES) begin
      run_cycle(1'b0, 1'b1);
    end
    check_bit("out_empty_n", out_empty_n, 1'b0);

    @(posedge clk);
    #1;
    in_enq  = 1'b0;
    out_deq = 1'b0;

    if (exp_q.size() != 0) begin
      other_errors++;
      $display("%0d expected beats never came out of the DUT", exp_q.size());
    end

    $display("errors: beat %0d, status %0d, other %0d",
             beat_errors, status_errors, other_errors);
    if (beat_errors + status_errors + other_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
deagg_pkg.sv
lane_fifo.sv
double_buffer.sv
deaggregator.sv
deagg_top.sv
tb_deagg.sv
